/* bgpu_macros.svh */
// Size constants for the single-warp dispatcher
// BGPU_NUM_TAGS must be a power of two and at least BGPU_WAIT_DEPTH
// Register count is two to the power of BGPU_REG_IDX_W

`ifndef BGPU_MACROS_SVH
`define BGPU_MACROS_SVH

// Instructions that may be in flight at once
`define BGPU_NUM_TAGS 8

// Register index width, 64 architectural registers
`define BGPU_REG_IDX_W 6

// Program counter width
`define BGPU_PC_W 16

// Instructions parked while waiting on operands
`define BGPU_WAIT_DEPTH 4

// Source operands per instruction
`define BGPU_NUM_OPS 2

`endif

/* bgpu_pkg.sv */
// Shared types for the dispatcher RTL and its testbench
// Widths all follow the macros, so change sizes there only

`include "bgpu_macros.svh"

package bgpu_pkg;

    // Instruction tag, one per in-flight instruction
    typedef logic [$clog2(`BGPU_NUM_TAGS)-1:0] tag_t;

    // Architectural register index
    typedef logic [`BGPU_REG_IDX_W-1:0] reg_idx_t;

    // Program counter
    typedef logic [`BGPU_PC_W-1:0] pc_t;

    // One bit per source operand
    typedef logic [`BGPU_NUM_OPS-1:0] op_mask_t;

    // Register index and producer tag per operand
    typedef reg_idx_t [`BGPU_NUM_OPS-1:0] op_reg_idx_t;
    typedef tag_t [`BGPU_NUM_OPS-1:0] op_tag_t;

    // Decoded instruction class
    typedef enum logic [3:0] {
        OP_ADD    = 4'h0,
        OP_SUB    = 4'h1,
        OP_MUL    = 4'h2,
        OP_LOAD   = 4'h3,
        OP_STORE  = 4'h4,
        OP_BRANCH = 4'h5
    } opcode_e;

    // Wait buffer slot state
    typedef enum logic [1:0] {
        ENTRY_FREE  = 2'b00,
        ENTRY_WAIT  = 2'b01,
        ENTRY_READY = 2'b10
    } entry_state_e;

endpackage

/* disp_insert_if.sv */
// One scoreboarded instruction on its way into the wait buffer
// No handshake back, the sender only raises valid when there is space

interface disp_insert_if import bgpu_pkg::*; ();

    logic        valid;
    tag_t        tag;
    pc_t         pc;
    opcode_e     opcode;
    // Destination register of the instruction
    reg_idx_t    dst_reg;
    op_mask_t    operands_is_reg;
    op_reg_idx_t operands;
    // Already masked, non-register operands read as ready
    op_mask_t    operands_ready;
    // Producer tag per operand, only meaningful while not ready
    op_tag_t     operand_tags;

    // Scoreboard side
    modport src (
        output valid, tag, pc, opcode, dst_reg,
        output operands_is_reg, operands, operands_ready, operand_tags
    );

    // Wait buffer side
    modport dst (
        input valid, tag, pc, opcode, dst_reg,
        input operands_is_reg, operands, operands_ready, operand_tags
    );

endinterface

/* tag_queue.sv */
// Circular FIFO of free instruction tags, full after reset
// NumTags must be a power of two, at least 2, and fit in tag_t
// Caller must never free more tags than were taken

`include "bgpu_macros.svh"

module tag_queue import bgpu_pkg::*; #(
    parameter int unsigned NumTags = `BGPU_NUM_TAGS
) (
    input  logic clk_i,
    input  logic reset_i,

    // Tag coming back from a writeback
    input  logic free_i,
    input  tag_t free_tag_i,

    // Tag handed to a new instruction
    input  logic get_i,
    output tag_t tag_o,
    output logic valid_o
);

    localparam int unsigned PtrW = $clog2(NumTags);

    tag_t             mem_q [NumTags];
    logic [PtrW-1:0]  rd_ptr_q;
    logic [PtrW-1:0]  wr_ptr_q;
    // One bit wider than the pointers so a full pool is visible
    logic [PtrW:0]    count_q;
    logic             pop;

    assign valid_o = (count_q != '0);
    assign tag_o   = mem_q[rd_ptr_q];
    // Pop only when something is there
    assign pop     = get_i && valid_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Pool starts holding every tag in order
            for (int i = 0; i < NumTags; i++) begin
                mem_q[i] <= tag_t'(i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= (PtrW+1)'(NumTags);
        end else begin
            if (free_i) begin
                mem_q[wr_ptr_q] <= free_tag_i;
                wr_ptr_q        <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({free_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* reg_table.sv */
// Register scoreboard, one in-flight bit and producer tag per register
// Lookups see the state before the current edge plus the writeback bypass
// An insert wins over a same-cycle clear of the same register

module reg_table import bgpu_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    // New instruction from the decoder
    input  logic        insert_i,
    input  tag_t        tag_i,
    input  reg_idx_t    dst_i,
    input  op_reg_idx_t operands_i,

    // Operand status for that instruction
    output op_mask_t    operands_ready_o,
    output op_tag_t     operands_tag_o,

    // Writeback
    input  logic        eu_valid_i,
    input  tag_t        eu_tag_i,

    // Nothing left in flight
    output logic        all_dst_written_o
);

    localparam int NumRegs = 2 ** $bits(reg_idx_t);
    localparam int NumOps  = $bits(op_mask_t);

    logic [NumRegs-1:0] busy_q;
    // Producer tags carry no reset, busy_q qualifies them
    tag_t               tag_q [NumRegs];

    // Operand lookup
    always_comb begin
        for (int i = 0; i < NumOps; i++) begin
            operands_tag_o[i]   = tag_q[operands_i[i]];
            // Free register, or its producer writes back right now
            operands_ready_o[i] = !busy_q[operands_i[i]]
                || (eu_valid_i && (tag_q[operands_i[i]] == eu_tag_i));
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            // Clear only where the stored tag still names this producer
            for (int r = 0; r < NumRegs; r++) begin
                if (eu_valid_i && busy_q[r] && (tag_q[r] == eu_tag_i)) begin
                    busy_q[r] <= 1'b0;
                end
            end
            // Later assignment, so it overrides the clear
            if (insert_i) begin
                busy_q[dst_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (insert_i) begin
            tag_q[dst_i] <= tag_i;
        end
    end

    assign all_dst_written_o = ~|busy_q;

endmodule

/* wait_buffer.sv */
// Parks scoreboarded instructions until all register operands are written
// Ages form a dense rank 0..n-1, the highest age is the oldest entry
// The presented entry is locked until the operand collector accepts it

`include "bgpu_macros.svh"

module wait_buffer import bgpu_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    // Insert side, always accepted
    disp_insert_if.dst  ins,
    output logic        space_o,

    // Writeback wake-up
    input  logic        eu_valid_i,
    input  tag_t        eu_tag_i,

    // Operand collector side
    input  logic        opc_ready_i,
    output logic        disp_valid_o,
    output tag_t        disp_tag_o,
    output pc_t         disp_pc_o,
    output opcode_e     disp_inst_o,
    output reg_idx_t    disp_dst_o,
    output op_mask_t    disp_operands_is_reg_o,
    output op_reg_idx_t disp_operands_o
);

    localparam int Depth  = `BGPU_WAIT_DEPTH;
    localparam int NumOps = `BGPU_NUM_OPS;
    localparam int IdxW   = (Depth > 1) ? $clog2(Depth) : 1;

    typedef logic [IdxW-1:0] idx_t;

    // ##########################################################
    // Entry storage
    // ##########################################################

    entry_state_e state_q [Depth];
    idx_t         age_q [Depth];
    tag_t         tag_q [Depth];
    pc_t          pc_q [Depth];
    opcode_e      opcode_q [Depth];
    reg_idx_t     dst_q [Depth];
    op_mask_t     is_reg_q [Depth];
    op_reg_idx_t  operands_q [Depth];
    op_mask_t     ready_q [Depth];
    op_tag_t      wait_tag_q [Depth];

    op_mask_t     woken [Depth];
    idx_t         free_idx;
    idx_t         oldest_idx;
    idx_t         oldest_age;
    logic         oldest_found;
    idx_t         sel_idx;
    idx_t         lock_idx_q;
    logic         locked_q;
    logic         remove;

    // Lowest free slot takes the next insert
    always_comb begin
        space_o  = 1'b0;
        free_idx = '0;
        for (int e = Depth - 1; e >= 0; e--) begin
            if (state_q[e] == ENTRY_FREE) begin
                space_o  = 1'b1;
                free_idx = idx_t'(e);
            end
        end
    end

    // Operand ready bits after this cycle's writeback
    always_comb begin
        for (int e = 0; e < Depth; e++) begin
            for (int o = 0; o < NumOps; o++) begin
                woken[e][o] = ready_q[e][o]
                    || (eu_valid_i && (wait_tag_q[e][o] == eu_tag_i));
            end
        end
    end

    // ##########################################################
    // Oldest ready selection
    // ##########################################################

    always_comb begin
        oldest_found = 1'b0;
        oldest_idx   = '0;
        oldest_age   = '0;
        for (int e = 0; e < Depth; e++) begin
            if ((state_q[e] == ENTRY_READY) && (!oldest_found || (age_q[e] > oldest_age))) begin
                oldest_found = 1'b1;
                oldest_idx   = idx_t'(e);
                oldest_age   = age_q[e];
            end
        end
    end

    // Stalled choice stays put even if an older entry wakes up
    assign sel_idx      = locked_q ? lock_idx_q : oldest_idx;
    assign disp_valid_o = (state_q[sel_idx] == ENTRY_READY);
    assign remove       = disp_valid_o && opc_ready_i;

    assign disp_tag_o             = tag_q[sel_idx];
    assign disp_pc_o              = pc_q[sel_idx];
    assign disp_inst_o            = opcode_q[sel_idx];
    assign disp_dst_o             = dst_q[sel_idx];
    assign disp_operands_is_reg_o = is_reg_q[sel_idx];
    assign disp_operands_o        = operands_q[sel_idx];

    // ##########################################################
    // State update
    // ##########################################################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int e = 0; e < Depth; e++) begin
                state_q[e] <= ENTRY_FREE;
            end
            locked_q <= 1'b0;
        end else begin
            locked_q <= disp_valid_o && !opc_ready_i;
            for (int e = 0; e < Depth; e++) begin
                if ((state_q[e] == ENTRY_WAIT) && (&woken[e])) begin
                    state_q[e] <= ENTRY_READY;
                end
            end
            if (remove) begin
                state_q[sel_idx] <= ENTRY_FREE;
            end
            // Free slot, so never the entry being removed
            if (ins.valid) begin
                state_q[free_idx] <= (&ins.operands_ready) ? ENTRY_READY : ENTRY_WAIT;
            end
        end
    end

    // Payload, ages and operand bits, qualified by state_q
    always_ff @(posedge clk_i) begin
        lock_idx_q <= sel_idx;
        for (int e = 0; e < Depth; e++) begin
            if (state_q[e] == ENTRY_WAIT) begin
                ready_q[e] <= woken[e];
            end
            // Older on every insert, close the gap left by a younger removal
            if (state_q[e] != ENTRY_FREE) begin
                age_q[e] <= age_q[e] + idx_t'(ins.valid)
                    - idx_t'(remove && (age_q[e] > age_q[sel_idx]));
            end
        end
        if (ins.valid) begin
            age_q[free_idx]      <= '0;
            tag_q[free_idx]      <= ins.tag;
            pc_q[free_idx]       <= ins.pc;
            opcode_q[free_idx]   <= ins.opcode;
            dst_q[free_idx]      <= ins.dst_reg;
            is_reg_q[free_idx]   <= ins.operands_is_reg;
            operands_q[free_idx] <= ins.operands;
            ready_q[free_idx]    <= ins.operands_ready;
            wait_tag_q[free_idx] <= ins.operand_tags;
        end
    end

endmodule

/* dispatcher.sv */
// Single-warp dispatcher, one decode and one writeback per cycle
// Decoder must hold its inputs stable while dec_valid_i waits for ready
// Every dispatched tag must come back exactly once on eu_tag_i

`include "bgpu_macros.svh"

module dispatcher import bgpu_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    // Decoder
    input  logic        dec_valid_i,
    output logic        disp_ready_o,
    input  pc_t         dec_pc_i,
    input  opcode_e     dec_inst_i,
    input  reg_idx_t    dec_dst_i,
    input  op_mask_t    dec_operands_is_reg_i,
    input  op_reg_idx_t dec_operands_i,

    // Operand collector
    input  logic        opc_ready_i,
    output logic        disp_valid_o,
    output tag_t        disp_tag_o,
    output pc_t         disp_pc_o,
    output opcode_e     disp_inst_o,
    output reg_idx_t    disp_dst_o,
    output op_mask_t    disp_operands_is_reg_o,
    output op_reg_idx_t disp_operands_o,

    // Execution unit writeback
    input  logic        eu_valid_i,
    input  tag_t        eu_tag_i,

    // High once nothing is left in flight
    output logic        ib_all_instr_finished_o
);

    // ##########################################################
    // Lookup stage
    // ##########################################################

    logic     insert;
    logic     tag_available;
    tag_t     new_tag;
    logic     wb_space;
    op_mask_t reg_ready;
    op_tag_t  reg_tags;

    disp_insert_if ins_if ();

    // Free tag and free slot, independent of dec_valid_i
    assign disp_ready_o = tag_available && wb_space;
    assign insert       = dec_valid_i && disp_ready_o;

    tag_queue #(
        .NumTags ( `BGPU_NUM_TAGS )
    ) i_tag_queue (
        .clk_i      ( clk_i         ),
        .reset_i    ( reset_i       ),
        // Writebacks refill the pool
        .free_i     ( eu_valid_i    ),
        .free_tag_i ( eu_tag_i      ),
        .get_i      ( insert        ),
        .tag_o      ( new_tag       ),
        .valid_o    ( tag_available )
    );

    reg_table i_reg_table (
        .clk_i             ( clk_i                   ),
        .reset_i           ( reset_i                 ),
        .insert_i          ( insert                  ),
        .tag_i             ( new_tag                 ),
        .dst_i             ( dec_dst_i               ),
        .operands_i        ( dec_operands_i          ),
        .operands_ready_o  ( reg_ready               ),
        .operands_tag_o    ( reg_tags                ),
        .eu_valid_i        ( eu_valid_i              ),
        .eu_tag_i          ( eu_tag_i                ),
        .all_dst_written_o ( ib_all_instr_finished_o )
    );

    // Insert bundle, immediates count as ready
    assign ins_if.valid           = insert;
    assign ins_if.tag             = new_tag;
    assign ins_if.pc              = dec_pc_i;
    assign ins_if.opcode          = dec_inst_i;
    assign ins_if.dst_reg         = dec_dst_i;
    assign ins_if.operands_is_reg = dec_operands_is_reg_i;
    assign ins_if.operands        = dec_operands_i;
    assign ins_if.operands_ready  = reg_ready | ~dec_operands_is_reg_i;
    assign ins_if.operand_tags    = reg_tags;

    // ##########################################################
    // Wait and issue stage
    // ##########################################################

    wait_buffer i_wait_buffer (
        .clk_i                  ( clk_i                  ),
        .reset_i                ( reset_i                ),
        .ins                    ( ins_if.dst             ),
        .space_o                ( wb_space               ),
        .eu_valid_i             ( eu_valid_i             ),
        .eu_tag_i               ( eu_tag_i               ),
        .opc_ready_i            ( opc_ready_i            ),
        .disp_valid_o           ( disp_valid_o           ),
        .disp_tag_o             ( disp_tag_o             ),
        .disp_pc_o              ( disp_pc_o              ),
        .disp_inst_o            ( disp_inst_o            ),
        .disp_dst_o             ( disp_dst_o             ),
        .disp_operands_is_reg_o ( disp_operands_is_reg_o ),
        .disp_operands_o        ( disp_operands_o        )
    );

    // A full wait buffer must never be starved of tags
    if (`BGPU_NUM_TAGS < `BGPU_WAIT_DEPTH) begin : g_size_check
        $error("Tag count must be at least the wait buffer depth");
    end

endmodule

/* tb_dispatcher_props.sv */
// Dispatch rule checks, bound into every dispatcher instance
// Shadow scoreboard is fed from the ports only and keyed by PC
// PCs must be unique and below 512 for the shadow to hold
// Each failure raises assert_errors in tb_dispatcher

`include "bgpu_macros.svh"

module tb_dispatcher_props import bgpu_pkg::*; (
    input logic        clk_i,
    input logic        reset_i,
    input logic        dec_valid_i,
    input logic        disp_ready_o,
    input pc_t         dec_pc_i,
    input opcode_e     dec_inst_i,
    input reg_idx_t    dec_dst_i,
    input op_mask_t    dec_operands_is_reg_i,
    input op_reg_idx_t dec_operands_i,
    input logic        opc_ready_i,
    input logic        disp_valid_o,
    input tag_t        disp_tag_o,
    input pc_t         disp_pc_o,
    input opcode_e     disp_inst_o,
    input reg_idx_t    disp_dst_o,
    input op_mask_t    disp_operands_is_reg_o,
    input op_reg_idx_t disp_operands_o,
    input logic        eu_valid_i,
    input tag_t        eu_tag_i,
    input logic        ib_all_instr_finished_o
);

    localparam int MaxInstr = 512;
    localparam int NumRegs  = 2 ** $bits(reg_idx_t);
    localparam int NumOps   = `BGPU_NUM_OPS;
    localparam int NumTags  = `BGPU_NUM_TAGS;

    typedef logic [8:0] iidx_t;

    // ############################################################
    // Shadow scoreboard
    // ############################################################

    logic                dec_fire;
    logic                disp_fire;
    iidx_t               dec_idx;
    iidx_t               disp_idx;
    iidx_t               wb_idx;

    // Life of each instruction, indexed by PC
    logic [MaxInstr-1:0] decoded_q;
    logic [MaxInstr-1:0] dispatched_q;
    logic [MaxInstr-1:0] written_q;
    // Producer of each register operand, as seen at decode
    op_mask_t            has_prod_q [MaxInstr];
    iidx_t               prod_q [MaxInstr][NumOps];
    opcode_e             inst_q [MaxInstr];
    reg_idx_t            dst_q [MaxInstr];
    op_mask_t            is_reg_q [MaxInstr];
    op_reg_idx_t         ops_q [MaxInstr];

    logic [NumRegs-1:0]  reg_busy_q;
    iidx_t               writer_q [NumRegs];
    logic [NumTags-1:0]  tag_busy_q;
    iidx_t               tag_idx_q [NumTags];
    int                  waiting_q;
    int                  outstanding_q;

    logic                deps_ok;
    logic                payload_ok;

    assign dec_fire  = dec_valid_i && disp_ready_o;
    assign disp_fire = disp_valid_o && opc_ready_i;
    assign dec_idx   = dec_pc_i[8:0];
    assign disp_idx  = disp_pc_o[8:0];
    // Tag to PC mapping is learned at dispatch
    assign wb_idx    = tag_idx_q[eu_tag_i];

    always_comb begin
        deps_ok = 1'b1;
        for (int o = 0; o < NumOps; o++) begin
            if (has_prod_q[disp_idx][o] && !written_q[prod_q[disp_idx][o]]) begin
                deps_ok = 1'b0;
            end
        end
        payload_ok = (inst_q[disp_idx] == disp_inst_o) && (dst_q[disp_idx] == disp_dst_o)
            && (is_reg_q[disp_idx] == disp_operands_is_reg_o)
            && (ops_q[disp_idx] == disp_operands_o);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decoded_q     <= '0;
            dispatched_q  <= '0;
            written_q     <= '0;
            reg_busy_q    <= '0;
            tag_busy_q    <= '0;
            waiting_q     <= 0;
            outstanding_q <= 0;
        end else begin
            waiting_q     <= waiting_q + int'(dec_fire) - int'(disp_fire);
            outstanding_q <= outstanding_q + int'(dec_fire) - int'(eu_valid_i);
            // Writeback first so a same-edge decode of that register wins
            if (eu_valid_i) begin
                written_q[wb_idx]    <= 1'b1;
                tag_busy_q[eu_tag_i] <= 1'b0;
                for (int r = 0; r < NumRegs; r++) begin
                    if (reg_busy_q[r] && (writer_q[r] == wb_idx)) begin
                        reg_busy_q[r] <= 1'b0;
                    end
                end
            end
            if (disp_fire) begin
                dispatched_q[disp_idx] <= 1'b1;
                tag_busy_q[disp_tag_o] <= 1'b1;
                tag_idx_q[disp_tag_o]  <= disp_idx;
            end
            if (dec_fire) begin
                decoded_q[dec_idx] <= 1'b1;
                inst_q[dec_idx]    <= dec_inst_i;
                dst_q[dec_idx]     <= dec_dst_i;
                is_reg_q[dec_idx]  <= dec_operands_is_reg_i;
                ops_q[dec_idx]     <= dec_operands_i;
                // Operands read the producer from before this decode
                for (int o = 0; o < NumOps; o++) begin
                    has_prod_q[dec_idx][o] <= dec_operands_is_reg_i[o]
                        && reg_busy_q[dec_operands_i[o]];
                    prod_q[dec_idx][o] <= writer_q[dec_operands_i[o]];
                end
                reg_busy_q[dec_dst_i] <= 1'b1;
                writer_q[dec_dst_i]   <= dec_idx;
            end
        end
    end

    // ############################################################
    // Assertions
    // ############################################################

    a_reset_state: assert property (@(posedge clk_i)
        $fell(reset_i) |-> !disp_valid_o && disp_ready_o && ib_all_instr_finished_o)
    else begin
        tb_dispatcher.assert_errors++;
        $error("Outputs were not in their reset state after reset");
    end

    // Held entry must not move or vanish under a stall
    a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o && !opc_ready_i |=> disp_valid_o && $stable({disp_tag_o, disp_pc_o,
        disp_inst_o, disp_dst_o, disp_operands_is_reg_o, disp_operands_o}))
    else begin
        tb_dispatcher.assert_errors++;
        $error("Dispatch outputs changed or valid dropped while stalled");
    end

    a_deps_written: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_fire |-> deps_ok)
    else begin
        tb_dispatcher.assert_errors++;
        $error("Instruction at pc %h dispatched before its producers wrote back", disp_pc_o);
    end

    a_dispatch_once: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_fire |-> decoded_q[disp_idx] && !dispatched_q[disp_idx])
    else begin
        tb_dispatcher.assert_errors++;
        $error("Instruction at pc %h dispatched without a pending decode", disp_pc_o);
    end

    a_payload: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_fire |-> payload_ok)
    else begin
        tb_dispatcher.assert_errors++;
        $error("[ERROR] disp_dst_o/disp_operands_o got %h/%h expected %h/%h",
            disp_dst_o, disp_operands_o, dst_q[disp_idx], ops_q[disp_idx]);
    end

    a_tag_unique: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_fire |-> !tag_busy_q[disp_tag_o])
    else begin
        tb_dispatcher.assert_errors++;
        $error("Tag %h dispatched while still outstanding", disp_tag_o);
    end

    // Ready tracks both the wait slots and the tag pool
    a_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_ready_o == ((waiting_q < `BGPU_WAIT_DEPTH) && (outstanding_q < NumTags)))
    else begin
        tb_dispatcher.assert_errors++;
        $error("[ERROR] disp_ready_o got %h expected %h", disp_ready_o,
            (waiting_q < `BGPU_WAIT_DEPTH) && (outstanding_q < NumTags));
    end

    // Finished once no register still waits on its latest producer
    // An older writer of a reused register may still be outstanding
    a_finished: assert property (@(posedge clk_i) disable iff (reset_i)
        ib_all_instr_finished_o == !(|reg_busy_q))
    else begin
        tb_dispatcher.assert_errors++;
        $error("[ERROR] ib_all_instr_finished_o got %h expected %h",
            ib_all_instr_finished_o, !(|reg_busy_q));
    end

endmodule

/* tb_dispatcher.sv */
// Random stimulus for the dispatcher, rule checks sit in the bound props
// PCs are instruction numbers, kept below 512 for the shadow scoreboard
// Registers are drawn from 0 to 7 so dependencies are frequent

`include "bgpu_macros.svh"

module tb_dispatcher import bgpu_pkg::*; ();

    localparam int NumInstr       = 400;
    localparam int CyclesPerInstr = 40;
    localparam int Period         = 20;
    localparam int DriveDelay     = 2;
    localparam int HandshakeLimit = 200;
    localparam int DrainLimit     = 2000;
    localparam int Seed           = 32'h9373;

    logic        clk_i;
    logic        reset_i;
    logic        dec_valid_i;
    logic        disp_ready_o;
    pc_t         dec_pc_i;
    opcode_e     dec_inst_i;
    reg_idx_t    dec_dst_i;
    op_mask_t    dec_operands_is_reg_i;
    op_reg_idx_t dec_operands_i;
    logic        opc_ready_i;
    logic        disp_valid_o;
    tag_t        disp_tag_o;
    pc_t         disp_pc_o;
    opcode_e     disp_inst_o;
    reg_idx_t    disp_dst_o;
    op_mask_t    disp_operands_is_reg_o;
    op_reg_idx_t disp_operands_o;
    logic        eu_valid_i;
    tag_t        eu_tag_i;
    logic        ib_all_instr_finished_o;

    // Raised from the bound assertions
    int   assert_errors = 0;
    int   run_errors    = 0;
    int   n_dispatched  = 0;
    int   n_written     = 0;
    int   stim_seed     = Seed;
    // Separate stream for the responder side
    int   resp_seed     = ~Seed;
    tag_t eu_queue [$];

    dispatcher i_dut (.*);

    bind dispatcher tb_dispatcher_props i_props (.*);

    initial begin
        clk_i = 1'b0;
        forever #(Period / 2) clk_i = ~clk_i;
    end

    // One decoder request, held until the handshake edge
    task automatic decode_one(input int pc);
        int waited;
        waited                = 0;
        dec_valid_i           = 1'b1;
        dec_pc_i              = pc_t'(pc);
        dec_inst_i            = opcode_e'($unsigned($random(stim_seed)) % 6);
        dec_dst_i             = reg_idx_t'($unsigned($random(stim_seed)) % 8);
        dec_operands_is_reg_i = op_mask_t'($random(stim_seed));
        for (int o = 0; o < `BGPU_NUM_OPS; o++) begin
            dec_operands_i[o] = reg_idx_t'($unsigned($random(stim_seed)) % 8);
        end
        @(posedge clk_i);
        while (!disp_ready_o && (waited < HandshakeLimit)) begin
            waited++;
            @(posedge clk_i);
        end
        if (!disp_ready_o) begin
            run_errors++;
            $display("Decoder handshake for pc %0h never completed", pc);
        end
        #DriveDelay;
        dec_valid_i = 1'b0;
        // Idle decoder cycle now and then
        if (($unsigned($random(stim_seed)) % 4) == 0) begin
            @(posedge clk_i);
            #DriveDelay;
        end
    endtask

    // ############################################################
    // Operand collector and execution unit responder
    // ############################################################

    initial begin
        int idx;
        opc_ready_i = 1'b0;
        eu_valid_i  = 1'b0;
        eu_tag_i    = '0;
        @(negedge reset_i);
        forever begin
            @(posedge clk_i);
            if (disp_valid_o && opc_ready_i) begin
                eu_queue.push_back(disp_tag_o);
                n_dispatched++;
            end
            if (eu_valid_i) begin
                n_written++;
            end
            #DriveDelay;
            // Stall about one cycle in four
            opc_ready_i = ($unsigned($random(resp_seed)) % 4) != 0;
            eu_valid_i  = 1'b0;
            // Random pick from the queue gives out-of-order writebacks
            if ((eu_queue.size() > 0) && (($unsigned($random(resp_seed)) % 2) == 1)) begin
                idx        = $unsigned($random(resp_seed)) % eu_queue.size();
                eu_tag_i   = eu_queue[idx];
                eu_queue.delete(idx);
                eu_valid_i = 1'b1;
            end
        end
    end

    // ############################################################
    // Main sequence and end of run
    // ############################################################

    initial begin
        int waited;
        reset_i               = 1'b1;
        dec_valid_i           = 1'b0;
        dec_pc_i              = '0;
        dec_inst_i            = OP_ADD;
        dec_dst_i             = '0;
        dec_operands_is_reg_i = '0;
        dec_operands_i        = '0;
        repeat (8) @(posedge clk_i);
        #DriveDelay;
        reset_i = 1'b0;
        for (int i = 0; i < NumInstr; i++) begin
            decode_one(i);
        end
        // Drain until every tag has come back
        waited = 0;
        while ((n_written < NumInstr) && (waited < DrainLimit)) begin
            waited++;
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        if (n_dispatched != NumInstr) begin
            run_errors++;
            $display("[ERROR] n_dispatched got %0h expected %0h", n_dispatched, NumInstr);
        end
        if (n_written != NumInstr) begin
            run_errors++;
            $display("[ERROR] n_written got %0h expected %0h", n_written, NumInstr);
        end
        if (ib_all_instr_finished_o !== 1'b1) begin
            run_errors++;
            $display("[ERROR] ib_all_instr_finished_o got %0h expected 1",
                ib_all_instr_finished_o);
        end
        $display("Errors: %0d from assertions, %0d from the run", assert_errors, run_errors);
        if ((assert_errors == 0) && (run_errors == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized for the longest expected run
    initial begin
        #(NumInstr * CyclesPerInstr * Period);
        $display("Watchdog expired after %0d cycles, the run did not finish",
            NumInstr * CyclesPerInstr);
        $display("Errors: %0d from assertions, %0d from the run", assert_errors, run_errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
bgpu_pkg.sv
disp_insert_if.sv
tag_queue.sv
reg_table.sv
wait_buffer.sv
dispatcher.sv
tb_dispatcher_props.sv
tb_dispatcher.sv

/* Bender.yml */
package:
  name: bgpu_dispatcher

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bgpu_pkg.sv
      - disp_insert_if.sv
      - tag_queue.sv
      - reg_table.sv
      - wait_buffer.sv
      - dispatcher.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_dispatcher_props.sv
      - tb_dispatcher.sv
